/* logic/pmp_pkg.sv */
`default_nettype none

package pmp_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------

  // Number of protection regions
  localparam int NUM_REGIONS  = 4;
  localparam int REGION_IDX_W = $clog2(NUM_REGIONS);

  // Physical request address, byte granular
  localparam int PHYS_ADDR_W  = 34;

  // Address register holds physical bits 33:2
  localparam int CSR_ADDR_W   = 32;

  // ------------------------------
  // Config byte layout
  // ------------------------------

  localparam int CFG_W        = 8;
  localparam int CFG_R_BIT    = 0;
  localparam int CFG_W_BIT    = 1;
  localparam int CFG_X_BIT    = 2;
  localparam int CFG_A_LSB    = 3;
  localparam int CFG_A_W      = 2;
  localparam int CFG_L_BIT    = 7;

  // ------------------------------
  // Encodings
  // ------------------------------

  // Address matching mode, the A field of the config byte
  typedef enum logic [CFG_A_W-1:0] {
    PMP_MODE_OFF   = 2'd0,
    PMP_MODE_TOR   = 2'd1,
    PMP_MODE_NA4   = 2'd2,
    PMP_MODE_NAPOT = 2'd3
  } pmp_mode_e;

  // Access type of a request
  typedef enum logic [1:0] {
    PMP_ACC_READ  = 2'd0,
    PMP_ACC_WRITE = 2'd1,
    PMP_ACC_EXEC  = 2'd2
  } pmp_acc_e;

  // Privilege level, only user and machine exist here
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

endpackage

`default_nettype wire

/* logic/pmp_csr_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pmp_csr_regs (
  input  wire                                              clk_i,
  input  wire                                              arst_n_i,

  // Config byte write
  input  wire                                              cfg_we_i,
  input  wire  [pmp_pkg::REGION_IDX_W-1:0]                 cfg_idx_i,
  input  wire  [pmp_pkg::CFG_W-1:0]                        cfg_wdata_i,

  // Address register write
  input  wire                                              addr_we_i,
  input  wire  [pmp_pkg::REGION_IDX_W-1:0]                 addr_idx_i,
  input  wire  [pmp_pkg::CSR_ADDR_W-1:0]                   addr_wdata_i,

  // Security bits write
  input  wire                                              sec_we_i,
  input  wire                                              sec_mml_wdata_i,
  input  wire                                              sec_mmwp_wdata_i,

  output logic [pmp_pkg::NUM_REGIONS*pmp_pkg::CFG_W-1:0]      cfg_o,
  output logic [pmp_pkg::NUM_REGIONS*pmp_pkg::CSR_ADDR_W-1:0] addr_o,
  output logic                                             mml_o,
  output logic                                             mmwp_o
);

  logic [pmp_pkg::CFG_W-1:0]      cfg_q  [pmp_pkg::NUM_REGIONS];
  logic [pmp_pkg::CSR_ADDR_W-1:0] addr_q [pmp_pkg::NUM_REGIONS];
  logic                           cfg_locked;
  logic                           addr_locked;

  // Lock state of the region addressed by each write port
  assign cfg_locked  = cfg_q[cfg_idx_i][pmp_pkg::CFG_L_BIT];
  assign addr_locked = cfg_q[addr_idx_i][pmp_pkg::CFG_L_BIT];

  // ------------------------------
  // Region registers
  // ------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
        cfg_q[i]  <= '0;
        addr_q[i] <= '0;
      end
    end else begin
      // A locked region stays frozen until reset
      if (cfg_we_i && !cfg_locked) begin
        cfg_q[cfg_idx_i] <= cfg_wdata_i;
      end
      if (addr_we_i && !addr_locked) begin
        addr_q[addr_idx_i] <= addr_wdata_i;
      end
    end
  end

  // Security bits, always writable
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mml_o  <= 1'b0;
      mmwp_o <= 1'b0;
    end else if (sec_we_i) begin
      mml_o  <= sec_mml_wdata_i;
      mmwp_o <= sec_mmwp_wdata_i;
    end
  end

  // Flat read side, no latency
  always_comb begin
    for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
      cfg_o[i*pmp_pkg::CFG_W +: pmp_pkg::CFG_W]            = cfg_q[i];
      addr_o[i*pmp_pkg::CSR_ADDR_W +: pmp_pkg::CSR_ADDR_W] = addr_q[i];
    end
  end

endmodule

`default_nettype wire

/* logic/pmp_region_match.sv */
`timescale 1ns/1ps
`default_nettype none

module pmp_region_match (
  input  wire pmp_pkg::pmp_mode_e           cfg_mode_i,
  input  wire [pmp_pkg::CSR_ADDR_W-1:0]     addr_i,
  input  wire [pmp_pkg::CSR_ADDR_W-1:0]     lower_addr_i,
  input  wire [pmp_pkg::PHYS_ADDR_W-1:0]    req_addr_i,
  output logic                              match_o
);

  logic [pmp_pkg::CSR_ADDR_W-1:0] req_word;
  logic [pmp_pkg::CSR_ADDR_W-1:0] napot_mask;
  logic                           tor_hit;
  logic                           na4_hit;
  logic                           napot_hit;

  // Word address of the request, bits 33:2
  assign req_word = req_addr_i[pmp_pkg::PHYS_ADDR_W-1:2];

  // ------------------------------
  // NAPOT mask
  // ------------------------------

  // Trailing ones plus the first zero encode the region size
  always_comb begin : napot_mask_gen
    logic seen_zero;
    seen_zero = 1'b0;
    for (int j = 0; j < pmp_pkg::CSR_ADDR_W; j++) begin
      napot_mask[j] = seen_zero;
      if (!addr_i[j]) begin
        seen_zero = 1'b1;
      end
    end
  end

  // ------------------------------
  // Address compares
  // ------------------------------

  // Range is [lower, upper)
  assign tor_hit   = (lower_addr_i <= req_word) && (req_word < addr_i);

  assign na4_hit   = (req_word == addr_i);

  assign napot_hit = ((req_word & napot_mask) == (addr_i & napot_mask));

  // Mode select, OFF never hits
  always_comb begin
    case (cfg_mode_i)
      pmp_pkg::PMP_MODE_TOR:   match_o = tor_hit;
      pmp_pkg::PMP_MODE_NA4:   match_o = na4_hit;
      pmp_pkg::PMP_MODE_NAPOT: match_o = napot_hit;
      default:                 match_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/pmp_perm_check.sv */
`timescale 1ns/1ps
`default_nettype none

module pmp_perm_check (
  input  wire                      matched_i,
  input  wire                      lock_i,
  input  wire                      read_i,
  input  wire                      write_i,
  input  wire                      exec_i,
  input  wire                      mml_i,
  input  wire                      mmwp_i,
  input  wire pmp_pkg::pmp_acc_e   req_type_i,
  input  wire pmp_pkg::priv_lvl_e  req_priv_i,
  output logic                     allowed_o
);

  logic [3:0] lrwx;
  logic       is_m_mode;
  logic       perm_bit;
  logic       mml_ok;
  logic       legacy_ok;
  logic       nomatch_ok;

  assign lrwx      = {lock_i, read_i, write_i, exec_i};
  assign is_m_mode = (req_priv_i == pmp_pkg::PRIV_LVL_M);

  // ------------------------------
  // MML table
  // ------------------------------

  // Whitelist of L,R,W,X patterns, everything else is denied
  always_comb begin
    mml_ok = 1'b0;
    case (req_type_i)
      pmp_pkg::PMP_ACC_READ: begin
        if (is_m_mode) begin
          mml_ok = lrwx inside {4'b0010, 4'b0011, 4'b1011, 4'b1100,
                                4'b1101, 4'b1110, 4'b1111};
        end else begin
          mml_ok = lrwx inside {4'b0010, 4'b0011, 4'b0100, 4'b0101,
                                4'b0110, 4'b0111, 4'b1111};
        end
      end
      pmp_pkg::PMP_ACC_WRITE: begin
        if (is_m_mode) begin
          mml_ok = lrwx inside {4'b0010, 4'b0011, 4'b1110};
        end else begin
          mml_ok = lrwx inside {4'b0011, 4'b0110, 4'b0111};
        end
      end
      pmp_pkg::PMP_ACC_EXEC: begin
        if (is_m_mode) begin
          mml_ok = lrwx inside {4'b1001, 4'b1010, 4'b1011, 4'b1101};
        end else begin
          mml_ok = lrwx inside {4'b0001, 4'b0101, 4'b0111, 4'b1010, 4'b1011};
        end
      end
      default: mml_ok = 1'b0;
    endcase
  end

  // ------------------------------
  // Legacy rules
  // ------------------------------

  always_comb begin
    case (req_type_i)
      pmp_pkg::PMP_ACC_READ:  perm_bit = read_i;
      pmp_pkg::PMP_ACC_WRITE: perm_bit = write_i;
      pmp_pkg::PMP_ACC_EXEC:  perm_bit = exec_i;
      default:                perm_bit = 1'b0;
    endcase
  end

  // M mode bypasses unlocked regions
  assign legacy_ok = (is_m_mode && !lock_i) || perm_bit;

  // ------------------------------
  // No matching region
  // ------------------------------

  always_comb begin
    nomatch_ok = 1'b0;
    if (is_m_mode) begin
      case (req_type_i)
        pmp_pkg::PMP_ACC_READ:  nomatch_ok = !mmwp_i;
        pmp_pkg::PMP_ACC_WRITE: nomatch_ok = !mmwp_i;
        pmp_pkg::PMP_ACC_EXEC:  nomatch_ok = !mmwp_i && !mml_i;
        default:                nomatch_ok = 1'b0;
      endcase
    end
  end

  assign allowed_o = !matched_i ? nomatch_ok :
                     mml_i      ? mml_ok     : legacy_ok;

endmodule

`default_nettype wire

/* logic/pmp_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module pmp_checker (
  input  wire                               clk_i,
  input  wire                               arst_n_i,
  input  wire                               cfg_we_i,
  input  wire  [pmp_pkg::REGION_IDX_W-1:0]  cfg_idx_i,
  input  wire  [pmp_pkg::CFG_W-1:0]         cfg_wdata_i,
  input  wire                               addr_we_i,
  input  wire  [pmp_pkg::REGION_IDX_W-1:0]  addr_idx_i,
  input  wire  [pmp_pkg::CSR_ADDR_W-1:0]    addr_wdata_i,
  input  wire                               sec_we_i,
  input  wire                               sec_mml_wdata_i,
  input  wire                               sec_mmwp_wdata_i,
  input  wire                               req_valid_i,
  input  wire  [pmp_pkg::PHYS_ADDR_W-1:0]   req_addr_i,
  input  wire pmp_pkg::pmp_acc_e            req_type_i,
  input  wire pmp_pkg::priv_lvl_e           req_priv_i,
  output logic                              rsp_valid_o,
  output logic                              rsp_allowed_o,
  output logic                              rsp_matched_o,
  output logic [pmp_pkg::REGION_IDX_W-1:0]  rsp_index_o
);

  logic [pmp_pkg::NUM_REGIONS*pmp_pkg::CFG_W-1:0]      cfg_flat;
  logic [pmp_pkg::NUM_REGIONS*pmp_pkg::CSR_ADDR_W-1:0] addr_flat;
  logic                                                mml;
  logic                                                mmwp;
  logic [pmp_pkg::NUM_REGIONS-1:0]                     region_match;
  logic                                                any_match;
  logic [pmp_pkg::REGION_IDX_W-1:0]                    sel_idx;
  logic [pmp_pkg::CFG_W-1:0]                           sel_cfg;
  logic                                                allowed;

  pmp_csr_regs u_csr_regs (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_idx_i        (cfg_idx_i),
    .cfg_wdata_i      (cfg_wdata_i),
    .addr_we_i        (addr_we_i),
    .addr_idx_i       (addr_idx_i),
    .addr_wdata_i     (addr_wdata_i),
    .sec_we_i         (sec_we_i),
    .sec_mml_wdata_i  (sec_mml_wdata_i),
    .sec_mmwp_wdata_i (sec_mmwp_wdata_i),
    .cfg_o            (cfg_flat),
    .addr_o           (addr_flat),
    .mml_o            (mml),
    .mmwp_o           (mmwp)
  );

  // ------------------------------
  // Per-region address match
  // ------------------------------

  for (genvar i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin : g_region
    logic [pmp_pkg::CSR_ADDR_W-1:0] lower_addr;

    // TOR lower bound is the previous region's address, zero for region 0
    if (i == 0) begin : g_first
      assign lower_addr = '0;
    end else begin : g_rest
      assign lower_addr = addr_flat[(i-1)*pmp_pkg::CSR_ADDR_W +: pmp_pkg::CSR_ADDR_W];
    end

    pmp_region_match u_match (
      .cfg_mode_i   (pmp_pkg::pmp_mode_e'(
                       cfg_flat[i*pmp_pkg::CFG_W + pmp_pkg::CFG_A_LSB +: pmp_pkg::CFG_A_W])),
      .addr_i       (addr_flat[i*pmp_pkg::CSR_ADDR_W +: pmp_pkg::CSR_ADDR_W]),
      .lower_addr_i (lower_addr),
      .req_addr_i   (req_addr_i),
      .match_o      (region_match[i])
    );
  end

  // Lowest index wins, so scan from the top down
  always_comb begin
    sel_idx = '0;
    for (int i = pmp_pkg::NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_match[i]) begin
        sel_idx = i[pmp_pkg::REGION_IDX_W-1:0];
      end
    end
  end

  assign any_match = |region_match;
  assign sel_cfg   = cfg_flat[sel_idx*pmp_pkg::CFG_W +: pmp_pkg::CFG_W];

  pmp_perm_check u_perm_check (
    .matched_i  (any_match),
    .lock_i     (sel_cfg[pmp_pkg::CFG_L_BIT]),
    .read_i     (sel_cfg[pmp_pkg::CFG_R_BIT]),
    .write_i    (sel_cfg[pmp_pkg::CFG_W_BIT]),
    .exec_i     (sel_cfg[pmp_pkg::CFG_X_BIT]),
    .mml_i      (mml),
    .mmwp_i     (mmwp),
    .req_type_i (req_type_i),
    .req_priv_i (req_priv_i),
    .allowed_o  (allowed)
  );

  // ------------------------------
  // Response register
  // ------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i;
    end
  end

  // Results held until the next request
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_allowed_o <= allowed;
      rsp_matched_o <= any_match;
      rsp_index_o   <= sel_idx;
    end
  end

endmodule

`default_nettype wire

/* tb/tb_pmp_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pmp_checker;

  localparam int CLK_HALF    = 2;
  localparam int RST_CYCLES  = 5;
  localparam int RSP_TIMEOUT = 10;

  logic                                clk_i;
  logic                                arst_n_i;
  logic                                cfg_we_i;
  logic [pmp_pkg::REGION_IDX_W-1:0]    cfg_idx_i;
  logic [pmp_pkg::CFG_W-1:0]           cfg_wdata_i;
  logic                                addr_we_i;
  logic [pmp_pkg::REGION_IDX_W-1:0]    addr_idx_i;
  logic [pmp_pkg::CSR_ADDR_W-1:0]      addr_wdata_i;
  logic                                sec_we_i;
  logic                                sec_mml_wdata_i;
  logic                                sec_mmwp_wdata_i;
  logic                                req_valid_i;
  logic [pmp_pkg::PHYS_ADDR_W-1:0]     req_addr_i;
  pmp_pkg::pmp_acc_e                   req_type_i;
  pmp_pkg::priv_lvl_e                  req_priv_i;
  logic                                rsp_valid_o;
  logic                                rsp_allowed_o;
  logic                                rsp_matched_o;
  logic [pmp_pkg::REGION_IDX_W-1:0]    rsp_index_o;

  int         errors;
  int         cycle_cnt;
  // Expected {allowed, matched, index} and launch edge of each open request
  logic [3:0] exp_q [$];
  int         issue_q [$];

  pmp_checker u_dut (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_idx_i        (cfg_idx_i),
    .cfg_wdata_i      (cfg_wdata_i),
    .addr_we_i        (addr_we_i),
    .addr_idx_i       (addr_idx_i),
    .addr_wdata_i     (addr_wdata_i),
    .sec_we_i         (sec_we_i),
    .sec_mml_wdata_i  (sec_mml_wdata_i),
    .sec_mmwp_wdata_i (sec_mmwp_wdata_i),
    .req_valid_i      (req_valid_i),
    .req_addr_i       (req_addr_i),
    .req_type_i       (req_type_i),
    .req_priv_i       (req_priv_i),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_allowed_o    (rsp_allowed_o),
    .rsp_matched_o    (rsp_matched_o),
    .rsp_index_o      (rsp_index_o)
  );

  always #CLK_HALF clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ------------------------------
  // Checking
  // ------------------------------

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Error: %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
      errors++;
    end
  endtask

  task automatic check_rsp(input logic [3:0] exp, input int issued);
    check_val("rsp_valid_o delay", 1, cycle_cnt - issued);
    check_val("rsp_allowed_o", exp[3], rsp_allowed_o);
    check_val("rsp_matched_o", exp[2], rsp_matched_o);
    // Index only means something when a region matched
    if (exp[2]) begin
      check_val("rsp_index_o", exp[1:0], rsp_index_o);
    end
  endtask

  // Responses sampled mid-cycle, in request order
  always @(negedge clk_i) begin
    if (rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Response seen at %0t with no request outstanding", $time);
        errors++;
      end else begin
        check_rsp(exp_q.pop_front(), issue_q.pop_front());
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  task automatic write_csr(input byte kind, input logic [35:0] a, input logic [35:0] b);
    @(posedge clk_i);
    if (kind == "C") begin
      cfg_we_i    <= 1'b1;
      cfg_idx_i   <= a[pmp_pkg::REGION_IDX_W-1:0];
      cfg_wdata_i <= b[pmp_pkg::CFG_W-1:0];
    end else if (kind == "A") begin
      addr_we_i    <= 1'b1;
      addr_idx_i   <= a[pmp_pkg::REGION_IDX_W-1:0];
      addr_wdata_i <= b[pmp_pkg::CSR_ADDR_W-1:0];
    end else begin
      sec_we_i         <= 1'b1;
      sec_mml_wdata_i  <= a[0];
      sec_mmwp_wdata_i <= b[0];
    end
    @(posedge clk_i);
    cfg_we_i  <= 1'b0;
    addr_we_i <= 1'b0;
    sec_we_i  <= 1'b0;
  endtask

  task automatic issue_req(input logic [35:0] addr, input logic [1:0] typ,
                           input logic [1:0] priv, input logic [3:0] exp);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_addr_i  <= addr[pmp_pkg::PHYS_ADDR_W-1:0];
    req_type_i  <= pmp_pkg::pmp_acc_e'(typ);
    req_priv_i  <= pmp_pkg::priv_lvl_e'(priv);
    exp_q.push_back(exp);
    // Counter update for this edge is still pending
    issue_q.push_back(cycle_cnt + 1);
  endtask

  task automatic wait_rsps();
    int waited;
    waited = 0;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    while (exp_q.size() > 0 && waited < RSP_TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_q.size() > 0) begin
      $display("Timeout: %0d responses missing after %0d cycles", exp_q.size(), RSP_TIMEOUT);
      errors++;
      exp_q.delete();
      issue_q.delete();
    end
  endtask

  initial begin
    int               fd;
    int               code;
    byte              cmd;
    logic [35:0]      f0, f1, f2, f3, f4, f5;
    logic [8*256-1:0] skip_line;

    errors           = 0;
    cycle_cnt        = 0;
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    cfg_we_i         = 1'b0;
    cfg_idx_i        = '0;
    cfg_wdata_i      = '0;
    addr_we_i        = 1'b0;
    addr_idx_i       = '0;
    addr_wdata_i     = '0;
    sec_we_i         = 1'b0;
    sec_mml_wdata_i  = 1'b0;
    sec_mmwp_wdata_i = 1'b0;
    req_valid_i      = 1'b0;
    req_addr_i       = '0;
    req_type_i       = pmp_pkg::PMP_ACC_READ;
    req_priv_i       = pmp_pkg::PRIV_LVL_M;

    repeat (RST_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_val("rsp_valid_o", 0, rsp_valid_o);

    fd = $fopen("tb/pmp_input_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tb/pmp_input_vectors.txt");
      errors++;
    end else begin
      while ($fscanf(fd, " %c", cmd) == 1) begin
        if (cmd == "#") begin
          code = $fgets(skip_line, fd);
        end else if (cmd == "C" || cmd == "A" || cmd == "S") begin
          code = $fscanf(fd, "%h %h", f0, f1);
          if (code != 2) begin
            $display("Malformed register write line in the vector file");
            errors++;
          end else begin
            write_csr(cmd, f0, f1);
          end
        end else if (cmd == "Q" || cmd == "K") begin
          code = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
          if (code != 6) begin
            $display("Malformed check line in the vector file");
            errors++;
          end else begin
            issue_req(f0, f1[1:0], f2[1:0], {f3[0], f4[0], f5[1:0]});
            if (cmd == "K") begin
              wait_rsps();
            end
          end
        end else begin
          $display("Unknown command '%c' in the vector file", cmd);
          errors++;
        end
      end
      $fclose(fd);
    end

    // A few idle cycles so a stray response is still caught
    repeat (3) @(posedge clk_i);
    $display("Vector run complete, errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/pmp_input_vectors.txt */
# C idx cfg | A idx addr[33:2] | S mml mmwp : register writes, all fields hex
# Q|K addr type priv allowed matched index : Q issues only, K issues then collects all
# type 0 read 1 write 2 exec, priv 0 U 3 M
# Nothing configured, no region matches
K 000001000 0 0 0 0 0
K 000001000 0 3 1 0 0
K 000001000 2 3 1 0 0
# R0 TOR [0,1000) R, R1 NA4 2000 RW, R2 NAPOT 4000 size 800 X, R3 TOR [43FC,5000) RWX
A 0 00000400
C 0 09
A 1 00000800
C 1 13
A 2 000010FF
C 2 1C
A 3 00001400
C 3 0F
K 000000FFC 0 0 1 1 0
K 000001000 0 0 0 0 0
K 000000000 1 0 0 1 0
K 000000010 1 3 1 1 0
K 000002003 1 0 1 1 1
K 000002004 0 0 0 0 0
K 000001FFC 0 0 0 0 0
K 000004000 2 0 1 1 2
K 0000047FC 0 0 0 1 2
K 000004800 0 0 1 1 3
K 000003FFC 2 0 0 0 0
K 000005000 0 0 0 0 0
# R1 switched off, then three requests back to back
C 1 03
Q 000002000 0 0 0 0 0
Q 000000FFC 0 0 1 1 0
K 000004800 1 0 1 1 3
# Lock R0, later writes to its config and address are dropped
C 0 89
K 000000100 1 3 0 1 0
C 0 0F
A 0 00000800
K 000000100 0 3 1 1 0
K 000000100 1 3 0 1 0
K 000001000 0 3 1 0 0
# MML on, R0 holds pattern 1100
S 1 0
K 000000100 0 3 1 1 0
K 000000100 0 0 0 1 0
K 000003FFC 2 3 0 0 0
K 000003FFC 0 3 1 0 0
# R3 pattern 0010
C 3 0A
K 000004800 0 0 1 1 3
K 000004800 1 0 0 1 3
K 000004800 1 3 1 1 3
K 000004800 2 3 0 1 3
# R3 pattern 0101
C 3 0D
K 000004800 0 0 1 1 3
K 000004800 0 3 0 1 3
K 000004800 2 0 1 1 3
# R3 pattern 1010, locked from here on
C 3 8A
K 000004800 2 0 1 1 3
K 000004800 2 3 1 1 3
K 000004800 0 3 0 1 3
# MMWP on, M mode loses no-match access
S 1 1
K 000003FFC 0 3 0 0 0
K 000003FFC 1 3 0 0 0

/* list.f */
logic/pmp_pkg.sv
logic/pmp_csr_regs.sv
logic/pmp_region_match.sv
logic/pmp_perm_check.sv
logic/pmp_checker.sv
tb/tb_pmp_checker.sv
